/* stepper_ctrl.f */
+incdir+hdl
hdl/stepper_pkg.sv
hdl/stepper_regs.sv
hdl/step_pulse_gen.sv
hdl/driver_spi_link.sv
hdl/motion_gate.sv
hdl/stepper_ctrl.sv
tests/stepper_ctrl_chk.sv
tests/stepper_ctrl_tb.sv

/* tests/stepper_ctrl_tb.sv */
`timescale 1ns/1ps
`include "stepper_defs.svh"

module stepper_ctrl_tb;

  import stepper_pkg::*;

  localparam int ROWS       = 6;
  localparam int POLL_LIMIT = 400;

  // one stimulus row with its expected fault
  typedef struct packed {
    half_period_t half_period;
    step_count_t  steps;
    logic         dir;
    spi_word_t    tx_word;
    spi_word_t    reply;
    logic         fault;
  } row_t;

  logic      clk_25mhz;
  logic      arst_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      miso;
  logic      step;
  logic      dir;
  logic      drv_en;
  logic      sck;
  logic      cs_n;
  logic      mosi;

  row_t      rows [ROWS];
  string     names [ROWS];
  string     cur_name;
  int        errors;
  int        checks;
  // driver chip model
  spi_word_t model_rx;
  spi_word_t reply_sh;
  spi_word_t reply_word;
  // step pin monitor
  logic      measuring;
  logic      step_prev;
  int        pulse_cnt;
  int        run_len;
  int        exp_half;
  logic      exp_dir;

  stepper_ctrl dut_i (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .miso      (miso),
    .prdata    (prdata),
    .step      (step),
    .dir       (dir),
    .drv_en    (drv_en),
    .sck       (sck),
    .cs_n      (cs_n),
    .mosi      (mosi)
  );

  // 25 MHz
  always #20 clk_25mhz = ~clk_25mhz;

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error: %s %s expected %0h actual %0h", cur_name, what, expected, actual);
    end
  endtask

  // setup phase, then access phase, no wait states
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge clk_25mhz);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk_25mhz);
    #1;
    penable = 1'b1;
    @(posedge clk_25mhz);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    @(posedge clk_25mhz);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk_25mhz);
    #1;
    penable = 1'b1;
    // mid access phase, prdata settled
    @(negedge clk_25mhz);
    data = prdata;
    @(posedge clk_25mhz);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // poll one busy bit of STATUS until it drops
  task automatic wait_status_clear(input int bit_idx, input string what);
    apb_data_t st;
    int        tries;
    tries = 0;
    st    = '1;
    while (st[bit_idx] && tries < POLL_LIMIT) begin
      apb_read(`REG_STATUS, st);
      tries++;
    end
    if (st[bit_idx]) begin
      errors++;
      $display("timeout: %s still busy after %0d status polls in %s",
               what, POLL_LIMIT, cur_name);
    end
  endtask

  task automatic add_row(input int idx, input string name, input int half, input int cnt,
                         input logic row_dir, input spi_word_t reply, input logic fault);
    names[idx]             = name;
    rows[idx].half_period  = half_period_t'(half);
    rows[idx].steps        = step_count_t'(cnt);
    rows[idx].dir          = row_dir;
    rows[idx].tx_word      = spi_word_t'($urandom);
    rows[idx].reply        = reply;
    rows[idx].fault        = fault;
  endtask

  // driver chip, captures mosi on rising sck
  always @(posedge sck) begin
    model_rx = {model_rx[`SPI_BITS-2:0], mosi};
  end

  // reply msb goes out as soon as the chip is selected
  always @(negedge cs_n) begin
    reply_sh = reply_word;
    #1;
    miso = reply_sh[`SPI_BITS-1];
  end

  // next reply bit after each falling sck
  always @(negedge sck) begin
    #1;
    reply_sh = {reply_sh[`SPI_BITS-2:0], 1'b0};
    miso     = reply_sh[`SPI_BITS-1];
  end

  // pulse count and widths, in clock cycles
  always @(negedge clk_25mhz) begin
    if (measuring) begin
      if (step && !step_prev) begin
        pulse_cnt++;
        // low gap between two pulses
        if (pulse_cnt > 1) begin
          check("low width", exp_half, run_len);
        end
        check("dir at pulse", exp_dir, dir);
        run_len = 0;
      end else if (!step && step_prev) begin
        check("high width", exp_half, run_len);
        run_len = 0;
      end
      run_len++;
      step_prev = step;
    end
  end

  initial begin
    row_t      r;
    apb_data_t rd;
    apb_data_t ctrl_base;
    void'($urandom(32'h9404_b3b0));
    errors     = 0;
    checks     = 0;
    cur_name   = "reset";
    clk_25mhz  = 1'b0;
    arst_n     = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    miso       = 1'b0;
    model_rx   = '0;
    reply_sh   = '0;
    reply_word = '0;
    measuring  = 1'b0;
    step_prev  = 1'b0;
    pulse_cnt  = 0;
    run_len    = 0;
    exp_half   = 1;
    exp_dir    = 1'b0;
    // name, half period, steps, dir, reply, fault
    add_row(0, "slow_fwd", 3, 4, 1'b1, 16'h1234, 1'b0);
    add_row(1, "fast_rev", 1, 6, 1'b0, 16'h0a5c, 1'b0);
    add_row(2, "zero_half", 0, 3, 1'b1, 16'h7fff, 1'b0);
    add_row(3, "zero_steps", 2, 0, 1'b0, 16'h0001, 1'b0);
    add_row(4, "drv_fault", 2, 5, 1'b1, 16'h8003, 1'b1);
    add_row(5, "after_clr", 5, 2, 1'b0, 16'h4321, 1'b0);
    repeat (2) @(posedge clk_25mhz);
    #1;
    arst_n = 1'b1;

    for (int i = 0; i < ROWS; i++) begin
      r         = rows[i];
      cur_name  = names[i];
      // enable plus the row's dir
      ctrl_base = {30'd0, r.dir, 1'b1};
      // driver frame first
      model_rx   = '0;
      reply_word = r.reply;
      apb_write(`REG_SPI_TX, apb_data_t'(r.tx_word));
      apb_write(`REG_CTRL, ctrl_base | 32'h8);
      wait_status_clear(1, "serial link");
      check("mosi word", r.tx_word, model_rx);
      apb_read(`REG_SPI_RX, rd);
      check("spi rx", r.reply, rd);
      apb_read(`REG_STATUS, rd);
      check("fault", r.fault, rd[2]);
      check("drv_en", !r.fault, rd[3]);
      check("drv_en pin", !r.fault, drv_en);
      // then the move
      exp_half = (r.half_period == '0) ? 1 : int'(r.half_period);
      exp_dir  = r.dir;
      apb_write(`REG_SPEED, apb_data_t'(r.half_period));
      apb_write(`REG_STEPS, apb_data_t'(r.steps));
      pulse_cnt = 0;
      step_prev = 1'b0;
      run_len   = 0;
      measuring = 1'b1;
      apb_write(`REG_CTRL, ctrl_base | 32'h4);
      // second start mid move with the other dir, to be dropped
      if (!r.fault && r.steps != '0) begin
        apb_write(`REG_CTRL, {30'd0, ~r.dir, 1'b1} | 32'h4);
      end
      wait_status_clear(0, "step generator");
      measuring = 1'b0;
      // a faulted driver gets no pulses
      check("step pulses", r.fault ? 32'd0 : 32'(r.steps), pulse_cnt);
      apb_read(`REG_STATUS, rd);
      check("motion_busy", 0, rd[0]);
      check("spi_busy", 0, rd[1]);
      check("steps_left", 0, rd[31:16]);
      if (r.fault) begin
        apb_write(`REG_CTRL, ctrl_base | 32'h10);
        apb_read(`REG_STATUS, rd);
        check("fault after clear", 0, rd[2]);
        check("drv_en after clear", 1, rd[3]);
        check("drv_en pin after clear", 1, drv_en);
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* tests/stepper_ctrl_chk.sv */
`timescale 1ns/1ps

module stepper_ctrl_chk (
  input logic clk_25mhz,
  input logic arst_n,
  input logic step,
  input logic dir,
  input logic abort,
  input logic motion_busy,
  input logic sck,
  input logic cs_n
);

  // a driver fault halts the generator itself, not only the pin
  abort_stops_move: assert property (
    @(posedge clk_25mhz) disable iff (!arst_n) abort |=> !motion_busy
  ) else $error("step generator still busy one cycle into a fault");

  // serial clock idles low outside a frame
  sck_idle_low: assert property (
    @(posedge clk_25mhz) disable iff (!arst_n) cs_n |-> !sck
  ) else $error("sck high while cs_n is high");

  // first high cycle may follow a new dir, later ones hold it
  dir_stable_in_pulse: assert property (
    @(posedge clk_25mhz) disable iff (!arst_n) (step && $past(step)) |-> $stable(dir)
  ) else $error("dir changed while step is high");

endmodule

bind stepper_ctrl stepper_ctrl_chk chk_i (
  .clk_25mhz   (clk_25mhz),
  .arst_n      (arst_n),
  .step        (step),
  .dir         (dir),
  .abort       (abort),
  .motion_busy (motion_stat.busy),
  .sck         (sck),
  .cs_n        (cs_n)
);

/* hdl/stepper_ctrl.sv */
`timescale 1ns/1ps

module stepper_ctrl (
  input  logic                   clk_25mhz,
  input  logic                   arst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  stepper_pkg::apb_addr_t paddr,
  input  stepper_pkg::apb_data_t pwdata,
  input  logic                   miso,
  output stepper_pkg::apb_data_t prdata,
  output logic                   step,
  output logic                   dir,
  output logic                   drv_en,
  output logic                   sck,
  output logic                   cs_n,
  output logic                   mosi
);

  import stepper_pkg::*;

  // commands from the register file
  motion_cmd_t  motion_cmd;
  spi_cmd_t     spi_cmd;
  logic         enable;
  logic         fault_clr;
  // engine results
  motion_stat_t motion_stat;
  spi_stat_t    spi_stat;
  // gate outputs back to the engines and registers
  ctrl_stat_t   ctrl_stat;
  logic         abort;

  stepper_regs regs_i (
    .clk_25mhz  (clk_25mhz),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .ctrl_stat  (ctrl_stat),
    .rx_word    (spi_stat.rx_word),
    .prdata     (prdata),
    .enable     (enable),
    .fault_clr  (fault_clr),
    .motion_cmd (motion_cmd),
    .spi_cmd    (spi_cmd)
  );

  step_pulse_gen step_gen_i (
    .clk_25mhz   (clk_25mhz),
    .arst_n      (arst_n),
    .motion_cmd  (motion_cmd),
    .abort       (abort),
    .motion_stat (motion_stat)
  );

  driver_spi_link spi_link_i (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .spi_cmd   (spi_cmd),
    .miso      (miso),
    .sck       (sck),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .spi_stat  (spi_stat)
  );

  motion_gate gate_i (
    .clk_25mhz   (clk_25mhz),
    .arst_n      (arst_n),
    .enable      (enable),
    .fault_clr   (fault_clr),
    .motion_cmd  (motion_cmd),
    .motion_stat (motion_stat),
    .spi_stat    (spi_stat),
    .step        (step),
    .dir         (dir),
    .drv_en      (drv_en),
    .abort       (abort),
    .ctrl_stat   (ctrl_stat)
  );

endmodule

/* hdl/motion_gate.sv */
`timescale 1ns/1ps
`include "stepper_defs.svh"

module motion_gate (
  input  logic                      clk_25mhz,
  input  logic                      arst_n,
  input  logic                      enable,
  input  logic                      fault_clr,
  input  stepper_pkg::motion_cmd_t  motion_cmd,
  input  stepper_pkg::motion_stat_t motion_stat,
  input  stepper_pkg::spi_stat_t    spi_stat,
  output logic                      step,
  output logic                      dir,
  output logic                      drv_en,
  output logic                      abort,
  output stepper_pkg::ctrl_stat_t   ctrl_stat
);

  // sticky driver fault
  logic fault_q;
  // direction held for the whole move
  logic dir_q;

  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      fault_q <= 1'b0;
      dir_q   <= 1'b0;
    end else begin
      if (fault_clr) begin
        fault_q <= 1'b0;
      end else if (spi_stat.done && spi_stat.rx_word[`FAULT_BIT]) begin
        fault_q <= 1'b1;
      end
      // same start the generator accepts
      if (motion_cmd.start && !motion_stat.busy) begin
        dir_q <= motion_cmd.dir;
      end
    end
  end

  // pin gating
  assign drv_en = enable & ~fault_q;
  assign step   = motion_stat.step & drv_en;
  assign dir    = dir_q;
  // a fault stops a running move
  assign abort  = fault_q;

  assign ctrl_stat.fault       = fault_q;
  assign ctrl_stat.drv_en      = drv_en;
  assign ctrl_stat.motion_busy = motion_stat.busy;
  assign ctrl_stat.spi_busy    = spi_stat.busy;
  assign ctrl_stat.steps_left  = motion_stat.steps_left;

endmodule

/* hdl/driver_spi_link.sv */
`timescale 1ns/1ps
`include "stepper_defs.svh"

module driver_spi_link (
  input  logic                   clk_25mhz,
  input  logic                   arst_n,
  input  stepper_pkg::spi_cmd_t  spi_cmd,
  input  logic                   miso,
  output logic                   sck,
  output logic                   cs_n,
  output logic                   mosi,
  output stepper_pkg::spi_stat_t spi_stat
);

  import stepper_pkg::*;

  localparam int DIV_W = $clog2(2 * `SCK_HALF);
  localparam int BIT_W = $clog2(`SPI_BITS);
  // divider value at which sck rises, and the last one of a period
  localparam logic [DIV_W-1:0] DIV_RISE = DIV_W'(`SCK_HALF - 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(2 * `SCK_HALF - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`SPI_BITS - 1);

  spi_state_t       state_q;
  logic [DIV_W-1:0] div_q;
  logic [BIT_W-1:0] bit_q;
  // outgoing bits, msb on the line
  spi_word_t        tx_q;
  // incoming bits, shifted in from the right
  spi_word_t        rx_q;
  spi_word_t        rx_word_q;
  logic             sck_q;
  logic             cs_n_q;
  logic             done_q;

  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= spi_idle;
      div_q     <= '0;
      bit_q     <= '0;
      tx_q      <= '0;
      rx_q      <= '0;
      rx_word_q <= '0;
      sck_q     <= 1'b0;
      cs_n_q    <= 1'b1;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        spi_idle: begin
          if (spi_cmd.go) begin
            // first bit is on mosi as soon as cs_n drops
            state_q <= spi_shift;
            cs_n_q  <= 1'b0;
            tx_q    <= spi_cmd.tx_word;
            div_q   <= '0;
            bit_q   <= '0;
          end
        end
        spi_shift: begin
          div_q <= div_q + 1'b1;
          if (div_q == DIV_RISE) begin
            // rising sck, sample the driver
            sck_q <= 1'b1;
            rx_q  <= {rx_q[`SPI_BITS-2:0], miso};
          end else if (div_q == DIV_LAST) begin
            // falling sck, next bit out
            sck_q <= 1'b0;
            div_q <= '0;
            tx_q  <= {tx_q[`SPI_BITS-2:0], 1'b0};
            bit_q <= bit_q + 1'b1;
            if (bit_q == BIT_LAST) begin
              state_q <= spi_finish;
            end
          end
        end
        spi_finish: begin
          state_q   <= spi_idle;
          cs_n_q    <= 1'b1;
          rx_word_q <= rx_q;
          done_q    <= 1'b1;
        end
        default: state_q <= spi_idle;
      endcase
    end
  end

  assign sck              = sck_q;
  assign cs_n             = cs_n_q;
  assign mosi             = tx_q[`SPI_BITS-1];
  assign spi_stat.busy    = (state_q != spi_idle);
  assign spi_stat.done    = done_q;
  assign spi_stat.rx_word = rx_word_q;

endmodule

/* hdl/step_pulse_gen.sv */
`timescale 1ns/1ps

module step_pulse_gen (
  input  logic                      clk_25mhz,
  input  logic                      arst_n,
  input  stepper_pkg::motion_cmd_t  motion_cmd,
  input  logic                      abort,
  output stepper_pkg::motion_stat_t motion_stat
);

  import stepper_pkg::*;

  step_state_t  state_q;
  // half period latched at start
  half_period_t period_q;
  // counts down the cycles of one phase
  half_period_t phase_q;
  step_count_t  left_q;
  logic         done_q;
  // zero half period runs as one
  half_period_t period_eff;

  assign period_eff = (motion_cmd.half_period == '0) ? half_period_t'(1)
                                                     : motion_cmd.half_period;

  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= step_idle;
      period_q <= '0;
      phase_q  <= '0;
      left_q   <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (abort) begin
        // stop at once, steps_left keeps its value
        state_q <= step_idle;
      end else begin
        case (state_q)
          step_idle: begin
            if (motion_cmd.start) begin
              left_q   <= motion_cmd.steps;
              period_q <= period_eff;
              phase_q  <= period_eff - 1'b1;
              if (motion_cmd.steps == '0) begin
                done_q <= 1'b1;
              end else begin
                state_q <= step_high;
              end
            end
          end
          step_high: begin
            if (phase_q == '0) begin
              // falling edge of step counts the pulse
              state_q <= step_low;
              phase_q <= period_q - 1'b1;
              left_q  <= left_q - 1'b1;
            end else begin
              phase_q <= phase_q - 1'b1;
            end
          end
          step_low: begin
            if (phase_q != '0) begin
              phase_q <= phase_q - 1'b1;
            end else if (left_q == '0) begin
              state_q <= step_idle;
              done_q  <= 1'b1;
            end else begin
              state_q <= step_high;
              phase_q <= period_q - 1'b1;
            end
          end
          default: state_q <= step_idle;
        endcase
      end
    end
  end

  assign motion_stat.busy       = (state_q != step_idle);
  assign motion_stat.done       = done_q;
  assign motion_stat.step       = (state_q == step_high);
  assign motion_stat.steps_left = left_q;

endmodule

/* hdl/stepper_regs.sv */
`timescale 1ns/1ps
`include "stepper_defs.svh"

module stepper_regs (
  input  logic                    clk_25mhz,
  input  logic                    arst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  stepper_pkg::apb_addr_t  paddr,
  input  stepper_pkg::apb_data_t  pwdata,
  input  stepper_pkg::ctrl_stat_t ctrl_stat,
  input  stepper_pkg::spi_word_t  rx_word,
  output stepper_pkg::apb_data_t  prdata,
  output logic                    enable,
  output logic                    fault_clr,
  output stepper_pkg::motion_cmd_t motion_cmd,
  output stepper_pkg::spi_cmd_t   spi_cmd
);

  import stepper_pkg::*;

  // stored ctrl bits
  logic         enable_q;
  logic         dir_q;
  // self clearing strobes
  logic         start_q;
  logic         go_q;
  logic         fault_clr_q;
  // stored fields
  half_period_t speed_q;
  step_count_t  steps_q;
  spi_word_t    spi_tx_q;
  // write in the access phase, no wait states
  logic         wr_en;

  assign wr_en = psel & penable & pwrite;

  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      enable_q    <= 1'b0;
      dir_q       <= 1'b0;
      start_q     <= 1'b0;
      go_q        <= 1'b0;
      fault_clr_q <= 1'b0;
      speed_q     <= '0;
      steps_q     <= '0;
      spi_tx_q    <= '0;
    end else begin
      // strobes last a single cycle
      start_q     <= 1'b0;
      go_q        <= 1'b0;
      fault_clr_q <= 1'b0;
      if (wr_en) begin
        case (paddr)
          `REG_CTRL: begin
            enable_q    <= pwdata[0];
            dir_q       <= pwdata[1];
            start_q     <= pwdata[2];
            go_q        <= pwdata[3];
            fault_clr_q <= pwdata[4];
          end
          `REG_SPEED:  speed_q  <= pwdata[`SPEED_BITS-1:0];
          `REG_STEPS:  steps_q  <= pwdata[`COUNT_BITS-1:0];
          `REG_SPI_TX: spi_tx_q <= pwdata[`SPI_BITS-1:0];
          default: ;
        endcase
      end
    end
  end

  // read mux, strobes read back as zero
  always_comb begin
    case (paddr)
      `REG_CTRL:   prdata = apb_data_t'({dir_q, enable_q});
      `REG_SPEED:  prdata = apb_data_t'(speed_q);
      `REG_STEPS:  prdata = apb_data_t'(steps_q);
      `REG_SPI_TX: prdata = apb_data_t'(spi_tx_q);
      `REG_STATUS: prdata = {ctrl_stat.steps_left, {(32-`COUNT_BITS-4){1'b0}},
                             ctrl_stat.drv_en, ctrl_stat.fault,
                             ctrl_stat.spi_busy, ctrl_stat.motion_busy};
      `REG_SPI_RX: prdata = apb_data_t'(rx_word);
      default:     prdata = '0;
    endcase
  end

  assign enable                 = enable_q;
  assign fault_clr              = fault_clr_q;
  assign motion_cmd.start       = start_q;
  assign motion_cmd.dir         = dir_q;
  assign motion_cmd.half_period = speed_q;
  assign motion_cmd.steps       = steps_q;
  assign spi_cmd.go             = go_q;
  assign spi_cmd.tx_word        = spi_tx_q;

endmodule

/* hdl/stepper_pkg.sv */
`include "stepper_defs.svh"

package stepper_pkg;

  // bus side
  typedef logic [7:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // cycles high, and again cycles low, of one step pulse
  typedef logic [`SPEED_BITS-1:0] half_period_t;
  typedef logic [`COUNT_BITS-1:0] step_count_t;
  // one driver frame
  typedef logic [`SPI_BITS-1:0] spi_word_t;

  // register file to step generator
  typedef struct packed {
    logic         start;
    logic         dir;
    half_period_t half_period;
    step_count_t  steps;
  } motion_cmd_t;

  // register file to serial link
  typedef struct packed {
    logic      go;
    spi_word_t tx_word;
  } spi_cmd_t;

  // step generator results
  typedef struct packed {
    logic        busy;
    logic        done;
    logic        step;
    step_count_t steps_left;
  } motion_stat_t;

  // serial link results
  typedef struct packed {
    logic      busy;
    logic      done;
    spi_word_t rx_word;
  } spi_stat_t;

  // combined status seen by software
  typedef struct packed {
    logic        fault;
    logic        drv_en;
    logic        motion_busy;
    logic        spi_busy;
    step_count_t steps_left;
  } ctrl_stat_t;

  typedef enum logic [1:0] {
    step_idle,
    step_high,
    step_low
  } step_state_t;

  typedef enum logic [1:0] {
    spi_idle,
    spi_shift,
    spi_finish
  } spi_state_t;

endpackage

/* hdl/stepper_defs.svh */
`ifndef STEPPER_DEFS_SVH
`define STEPPER_DEFS_SVH

// apb register map, byte offsets
`define REG_CTRL   8'h00
`define REG_SPEED  8'h04
`define REG_STEPS  8'h08
`define REG_SPI_TX 8'h0C
`define REG_STATUS 8'h10
`define REG_SPI_RX 8'h14

// clock cycles per half of the serial clock
`define SCK_HALF 2

// reply bit the driver chip raises on a fault
`define FAULT_BIT 15

// frame length of the driver link
`define SPI_BITS 16

// step half period and step counter widths
`define SPEED_BITS 16
`define COUNT_BITS 16

`endif
